// ==== project.f ====
+incdir+testbench
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/inst_decode.sv
rtl/alu_execute.sv
rtl/reg_result.sv
rtl/core_top.sv
testbench/core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module core_tb
	out=$$(./obj_dir/Vcore_tb); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== testbench/core_ref.svh ====
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

function automatic word_t enc_r(input funct7_t f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input funct3_t f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                input funct3_t f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic word_t enc_u(input opcode_t opc, input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, opc};
endfunction

// RV32I result in value and a low return for encodings the core rejects
function automatic logic ref_exec(input word_t ins, input word_t pc,
                                  input word_t regs [NUM_REGS], output word_t value);
    funct3_t f3;
    logic    alt;
    word_t   a;
    word_t   b;
    f3  = ins[14:12];
    alt = ins[31:25] == F7_ALT;
    a   = regs[ins[19:15]];
    b   = (ins[6:0] == OPC_OP) ? regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    case (f3)
        F3_ADD_SUB: value = (alt && ins[6:0] == OPC_OP) ? a - b : a + b;   // no subi
        F3_SLL:     value = a << b[4:0];
        F3_SLT:     value = {31'd0, $signed(a) < $signed(b)};
        F3_SLTU:    value = {31'd0, a < b};
        F3_XOR:     value = a ^ b;
        F3_SRL_SRA: value = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        F3_OR:      value = a | b;
        default:    value = a & b;
    endcase
    if (ins[6:0] == OPC_LUI) value = {ins[31:12], 12'h000};
    if (ins[6:0] == OPC_AUIPC) value = pc + {ins[31:12], 12'h000};
    case (ins[6:0])
        OPC_LUI, OPC_AUIPC: return 1'b1;
        OPC_OP:     return ins[31:25] == F7_BASE ||
                           (alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
        OPC_OP_IMM: return (f3 != F3_SLL && f3 != F3_SRL_SRA) || ins[31:25] == F7_BASE ||
                           (alt && f3 == F3_SRL_SRA);
        default:    return 1'b0;
    endcase
endfunction

`endif

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    import isa_pkg::*;

    localparam int N_RAND     = 600;
    localparam int MAX_CYCLES = 4 + 2 * (NUM_REGS - 1) + 2 + N_RAND + 50;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
        word_t    pc;
        word_t    cyc;
    } expect_t;

    logic     clk;
    logic     reset;
    logic     inst_valid;
    word_t    inst;
    logic     retire_valid;
    reg_idx_t retire_rd;
    word_t    retire_value;
    word_t    retire_pc;
    logic     illegal_inst;

    int      seed = 93013;
    int      cycle = 0;
    int      mismatches = 0;
    int      other_errors = 0;
    word_t   model_regs [NUM_REGS];
    word_t   model_pc;
    expect_t exp_q [$];
    word_t   ill_q [$];   // cycle where each illegal pulse is due

    `include "core_ref.svh"

    core_top core_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout at cycle %0d, %0d retires outstanding", cycle, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected) else begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic issue(input word_t ins);
        word_t   value;
        expect_t e;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= ins;
        if (ref_exec(ins, model_pc, model_regs, value)) begin
            e = '{rd: ins[11:7], value: value, pc: model_pc, cyc: cycle + 3};  // sampled at +1
            exp_q.push_back(e);
            if (ins[11:7] != 5'd0) model_regs[ins[11:7]] = value;
        end else begin
            ill_q.push_back(cycle + 2);
        end
        model_pc = model_pc + PC_STEP;
    endtask

    task automatic idle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= rand_word();
    endtask

    always @(posedge clk) begin
        if (!reset && retire_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("%0t: an instruction retired with none outstanding", $time);
            end else begin
                check_value("retire_rd", 32'(retire_rd), 32'(exp_q[0].rd));
                check_value("retire_value", retire_value, exp_q[0].value);
                check_value("retire_pc", retire_pc, exp_q[0].pc);
                check_value("retire cycle", cycle, exp_q[0].cyc);
                void'(exp_q.pop_front());
            end
        end
        if (!reset && illegal_inst) begin
            if (ill_q.size() == 0) begin
                other_errors++;
                $display("%0t: illegal_inst pulsed for a legal instruction", $time);
            end else begin
                check_value("illegal_inst cycle", cycle, ill_q.pop_front());
            end
        end
    end

    initial begin
        word_t    r;
        word_t    r2;
        funct3_t  f3;
        funct7_t  f7;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t hist [4];
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        model_pc   = RESET_PC;
        model_regs = '{default: '0};
        hist       = '{default: '0};
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 1; i < NUM_REGS; i++) begin
            r = rand_word();
            issue(enc_u(OPC_LUI, r[31:12], 5'(i)));
            issue(enc_i(r[11:0], 5'(i), F3_ADD_SUB, 5'(i)));   // reads the lui at distance 1
        end
        issue(enc_i(12'h123, 5'd1, F3_ADD_SUB, 5'd0));
        issue(enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd2));   // x0 must read zero
        for (int i = 0; i < N_RAND; i++) begin
            r   = rand_word();
            r2  = rand_word();
            f3  = r[28:26];
            // sources lean on recent destinations
            rs1 = r[8] ? hist[r[7:6]] : r[13:9];
            rs2 = r[14] ? hist[r[16:15]] : r[21:17];
            f7  = r[29] ? F7_ALT : F7_BASE;   // alt on other ops is rejected
            if (r[25:22] == 4'd0) begin
                idle();
            end else if (r[25:22] == 4'd1) begin
                issue(r[30] ? enc_r(7'b0000001, rs2, rs1, f3, r[4:0]) : {r2[31:7], 7'b1100011});
            end else if (r[25:22] < 4'd4) begin
                issue(enc_u(r[22] ? OPC_AUIPC : OPC_LUI, r2[19:0], r[4:0]));
            end else if (r[25:22] < 4'd10) begin
                issue(enc_r(f7, rs2, rs1, f3, r[4:0]));
            end else if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                issue(enc_i({f7, r2[4:0]}, rs1, f3, r[4:0]));
            end else begin
                issue(enc_i(r2[11:0], rs1, f3, r[4:0]));
            end
            hist = '{r[4:0], hist[0], hist[1], hist[2]};
        end
        idle();
        while (exp_q.size() != 0 || ill_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_valid,
    input  isa_pkg::word_t    inst,
    output logic              retire_valid,
    output isa_pkg::reg_idx_t retire_rd,
    output isa_pkg::word_t    retire_value,
    output isa_pkg::word_t    retire_pc,
    output logic              illegal_inst
);
    import isa_pkg::*;
    import pipe_pkg::*;

    dec_op_t  dec;
    exe_res_t res;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    inst_decode inst_decode_inst (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .dec          (dec),
        .illegal_inst (illegal_inst)
    );

    alu_execute alu_execute_inst (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .res   (res)
    );

    reg_result reg_result_inst (
        .clk          (clk),
        .reset        (reset),
        .res          (res),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .retire_pc    (retire_pc)
    );

endmodule

// ==== rtl/reg_result.sv ====
`timescale 1ns/1ps

module reg_result (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::exe_res_t res,
    input  isa_pkg::reg_idx_t  rs1_idx,
    input  isa_pkg::reg_idx_t  rs2_idx,
    output isa_pkg::word_t     rs1_data,
    output isa_pkg::word_t     rs2_data,
    output logic               retire_valid,
    output isa_pkg::reg_idx_t  retire_rd,
    output isa_pkg::word_t     retire_value,
    output isa_pkg::word_t     retire_pc
);
    import isa_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = res.valid && (res.rd != '0);   // x0 ignores writes

    // write-through covers a reader two behind the writer
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && (res.rd == idx)) begin
            return res.value;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res.rd] <= res.value;
        end
    end

    // x0 writes still show on the retire port
    assign retire_valid = res.valid;
    assign retire_rd    = res.rd;
    assign retire_value = res.value;
    assign retire_pc    = res.pc;

    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

// ==== rtl/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::dec_op_t  dec,
    output pipe_pkg::exe_res_t res
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic               fwd_rs1;
    logic               fwd_rs2;
    word_t              rs1_val;
    word_t              rs2_val;
    word_t              op_a;
    word_t              op_b;
    word_t              result;
    logic [SHAMT_W-1:0] shamt;
    exe_res_t           res_next;

    // previous instruction's result is not in the file yet
    assign fwd_rs1 = res.valid && (res.rd != '0) && (res.rd == dec.rs1);
    assign fwd_rs2 = res.valid && (res.rd != '0) && (res.rd == dec.rs2);
    assign rs1_val = fwd_rs1 ? res.value : dec.rs1_val;
    assign rs2_val = fwd_rs2 ? res.value : dec.rs2_val;

    always_comb begin
        case (dec.src_a)
            SRC_A_PC:   op_a = dec.pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_val;
        endcase
    end

    assign op_b  = dec.b_is_imm ? dec.imm : rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (dec.op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $signed(op_a) >>> shamt;
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;   // add, lui, auipc
        endcase
    end

    always_comb begin
        res_next.valid = dec.valid;
        res_next.rd    = dec.rd;
        res_next.value = result;
        res_next.pc    = dec.pc;
    end

    always_ff @(posedge clk) begin
        res <= res_next;
        if (reset) begin
            res.valid <= 1'b0;
        end
    end

    // operands come from decode, the file and the forward path
    a_result_known: assert property (@(posedge clk) disable iff (reset)
        res.valid |-> !$isunknown(res.value));

endmodule

// ==== rtl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_valid,
    input  isa_pkg::word_t    inst,
    input  isa_pkg::word_t    rs1_data,
    input  isa_pkg::word_t    rs2_data,
    output isa_pkg::reg_idx_t rs1_idx,
    output isa_pkg::reg_idx_t rs2_idx,
    output pipe_pkg::dec_op_t dec,
    output logic              illegal_inst
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_u;
    word_t   pc;
    logic    illegal;
    dec_op_t dec_next;

    function automatic alu_op_e alu_op_sel(input funct3_t f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign imm_i   = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u   = {inst[31:12], 12'b0};

    always_comb begin
        dec_next.op       = ALU_ADD;
        dec_next.src_a    = SRC_A_REG;
        dec_next.b_is_imm = 1'b0;
        dec_next.rd       = inst[11:7];
        dec_next.rs1      = rs1_idx;
        dec_next.rs2      = rs2_idx;
        dec_next.rs1_val  = rs1_data;
        dec_next.rs2_val  = rs2_data;
        dec_next.imm      = imm_i;
        dec_next.pc       = pc;
        illegal           = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_next.op = alu_op_sel(funct3, funct7 == F7_ALT);
                illegal = (funct7 != F7_BASE) &&
                          !(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_OP_IMM: begin
                // funct7 is immediate except for the shifts
                dec_next.op       = alu_op_sel(funct3, funct3 == F3_SRL_SRA && funct7 == F7_ALT);
                dec_next.b_is_imm = 1'b1;
                illegal = (funct3 == F3_SLL && funct7 != F7_BASE) ||
                          (funct3 == F3_SRL_SRA && funct7 != F7_BASE && funct7 != F7_ALT);
            end
            OPC_LUI: begin
                dec_next.src_a    = SRC_A_ZERO;
                dec_next.b_is_imm = 1'b1;
                dec_next.imm      = imm_u;
            end
            OPC_AUIPC: begin
                dec_next.src_a    = SRC_A_PC;
                dec_next.b_is_imm = 1'b1;
                dec_next.imm      = imm_u;
            end
            default: illegal = 1'b1;
        endcase
        dec_next.valid = inst_valid && !illegal;
    end

    always_ff @(posedge clk) begin
        dec <= dec_next;
        if (reset) begin
            dec.valid    <= 1'b0;
            illegal_inst <= 1'b0;
            pc           <= RESET_PC;
        end else begin
            illegal_inst <= inst_valid && illegal;
            if (inst_valid) begin
                pc <= pc + PC_STEP;   // illegal ones step too
            end
        end
    end

    a_illegal_not_issued: assert property (@(posedge clk) disable iff (reset)
        !(illegal_inst && dec.valid));

endmodule

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

    // decode register read by execute
    typedef struct packed {
        logic              valid;
        isa_pkg::alu_op_e  op;
        isa_pkg::src_a_e   src_a;
        logic              b_is_imm;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::word_t    rs1_val;    // may be stale by one cycle
        isa_pkg::word_t    rs2_val;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    pc;
    } dec_op_t;

    // execute register written back and retired by reg_result
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    value;
        isa_pkg::word_t    pc;
    } exe_res_t;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int SHAMT_W  = $clog2(XLEN);

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [6:0]                  opcode_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [6:0]                  funct7_t;

    localparam word_t RESET_PC = '0;
    localparam word_t PC_STEP  = 32'd4;

    // RV32I major opcodes kept by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;   // sub, sra

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_REG,
        SRC_A_PC,
        SRC_A_ZERO   // lui
    } src_a_e;

endpackage
